// File: source/scene_pkg.sv
`default_nettype none

package scene_pkg;

  localparam int INST_W  = 40;
  localparam int COLOR_W = 12; // 4 bits each of r, g, b
  localparam int COORD_W = 4;
  localparam int DEPTH_W = 4;
  localparam int SLOT_W  = 2;

  typedef enum logic [1:0] {
    op_nop        = 2'd0,
    op_background = 2'd1,
    op_shape      = 2'd2,
    op_render     = 2'd3
  } opcode_e;

  typedef logic [COLOR_W-1:0] color_t;
  typedef logic [COORD_W-1:0] coord_t;
  typedef logic [DEPTH_W-1:0] depth_t;

  // axis-aligned rectangle, bounds are inclusive
  typedef struct packed {
    logic   enable;
    coord_t x0;
    coord_t y0;
    coord_t x1;
    coord_t y1;
    depth_t depth;
    color_t color;
  } shape_t;

  // shape write view of an instruction
  typedef struct packed {
    opcode_e             opcode;
    logic [SLOT_W-1:0]   slot;
    shape_t              shape;
    logic [2:0]          pad;
  } shape_inst_t;

  // background / render / nop view
  typedef struct packed {
    opcode_e             opcode;
    logic [25:0]         pad;
    color_t              bg_color;
  } ctrl_inst_t;

  typedef union packed {
    shape_inst_t shp;
    ctrl_inst_t  ctl;
  } inst_word_u;

endpackage

`default_nettype wire

// File: source/decode_if.sv
`default_nettype none
`timescale 1ns/1ps

// decoded scene updates and render command out of the decode stage
interface decode_if;
  import scene_pkg::*;

  logic              shape_we;
  logic [SLOT_W-1:0] shape_slot;
  shape_t            shape_data;
  logic              bg_we;
  color_t            bg_color;
  logic              render_start;

  modport decoder (
    output shape_we, shape_slot, shape_data, bg_we, bg_color, render_start
  );

  modport engine (input shape_we, shape_slot, shape_data, render_start);

  modport resolver (input bg_we, bg_color);

endinterface

`default_nettype wire

// File: source/hit_if.sv
`default_nettype none
`timescale 1ns/1ps

// one candidate per cycle, one per shape slot of the current pixel
interface hit_if;
  import scene_pkg::*;

  logic   cand_valid;
  logic   cand_hit;   // slot enabled and covers the pixel
  depth_t cand_depth;
  color_t cand_color;
  logic   cand_last;  // final slot of this pixel
  coord_t cand_x;
  coord_t cand_y;

  modport engine (
    output cand_valid, cand_hit, cand_depth, cand_color, cand_last,
    output cand_x, cand_y
  );

  modport resolver (
    input cand_valid, cand_hit, cand_depth, cand_color, cand_last,
    input cand_x, cand_y
  );

endinterface

`default_nettype wire

// File: source/scene_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module scene_decoder (
  input wire               sys_clk,
  input wire               sys_rst,
  input wire               inst_valid,
  input wire scene_pkg::inst_word_u inst_word,
  input wire               busy,
  decode_if.decoder        dec
);
  import scene_pkg::*;

  logic    accept;
  opcode_e opcode;

  // opcode sits in the same top bits in both views
  assign opcode = inst_word.ctl.opcode;
  assign accept = inst_valid && !busy; // anything during a frame is dropped

  // strobes, one cycle per accepted instruction
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      dec.shape_we     <= 1'b0;
      dec.bg_we        <= 1'b0;
      dec.render_start <= 1'b0;
    end else begin
      dec.shape_we     <= accept && (opcode == op_shape);
      dec.bg_we        <= accept && (opcode == op_background);
      dec.render_start <= accept && (opcode == op_render);
    end
  end

  // payload fields
  always_ff @(posedge sys_clk) begin
    if (accept && opcode == op_shape) begin
      dec.shape_slot <= inst_word.shp.slot;
      dec.shape_data <= inst_word.shp.shape;
    end
    if (accept && opcode == op_background) begin
      dec.bg_color <= inst_word.ctl.bg_color;
    end
  end

endmodule

`default_nettype wire

// File: source/raycast_engine.sv
`default_nettype none
`timescale 1ns/1ps

module raycast_engine #(
  parameter int FRAME_W    = 16,
  parameter int FRAME_H    = 12,
  parameter int NUM_SHAPES = 4
) (
  input wire     sys_clk,
  input wire     sys_rst,
  decode_if.engine dec,
  hit_if.engine  hit,
  output logic   busy
);
  import scene_pkg::*;

  localparam coord_t            LAST_X    = coord_t'(FRAME_W - 1);
  localparam coord_t            LAST_Y    = coord_t'(FRAME_H - 1);
  localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(NUM_SHAPES - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_scan,
    st_drain
  } state_e;

  state_e                  state;
  coord_t                  px;
  coord_t                  py;
  logic [SLOT_W-1:0]       slot;
  logic                    drain_cnt;
  logic [NUM_SHAPES-1:0]   shape_en;
  shape_t                  shape_tab [NUM_SHAPES];
  shape_t                  cur;
  logic                    in_x;
  logic                    in_y;
  logic                    slot_hit;

  assign busy = (state != st_idle);

  // payload of each table entry
  always_ff @(posedge sys_clk) begin
    if (dec.shape_we && int'(dec.shape_slot) < NUM_SHAPES) begin
      shape_tab[dec.shape_slot] <= dec.shape_data;
    end
  end

  // per-slot enable bits
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      shape_en <= '0;
    end else if (dec.shape_we && int'(dec.shape_slot) < NUM_SHAPES) begin
      shape_en[dec.shape_slot] <= dec.shape_data.enable;
    end
  end

  // coverage test for the slot under the counters
  always_comb begin
    cur      = shape_tab[slot];
    in_x     = (px >= cur.x0) && (px <= cur.x1);
    in_y     = (py >= cur.y0) && (py <= cur.y1);
    slot_hit = shape_en[slot] && in_x && in_y;
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      state     <= st_idle;
      px        <= '0;
      py        <= '0;
      slot      <= '0;
      drain_cnt <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (dec.render_start) begin
            state <= st_scan;
            px    <= '0;
            py    <= '0;
            slot  <= '0;
          end
        end
        st_scan: begin
          if (slot == LAST_SLOT) begin
            slot <= '0;
            if (px == LAST_X) begin
              px <= '0;
              if (py == LAST_Y) begin
                state     <= st_drain; // wait for resolver to emit last pixel
                drain_cnt <= 1'b0;
              end else begin
                py <= py + 1'b1;
              end
            end else begin
              px <= px + 1'b1;
            end
          end else begin
            slot <= slot + 1'b1;
          end
        end
        st_drain: begin
          // two cycles for the last candidate and the resolver output
          if (drain_cnt) begin
            state <= st_idle;
          end
          drain_cnt <= 1'b1;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // candidate register
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      hit.cand_valid <= 1'b0;
    end else begin
      hit.cand_valid <= (state == st_scan);
    end
  end

  always_ff @(posedge sys_clk) begin
    hit.cand_hit   <= slot_hit;
    hit.cand_depth <= cur.depth;
    hit.cand_color <= cur.color;
    hit.cand_last  <= (slot == LAST_SLOT);
    hit.cand_x     <= px;
    hit.cand_y     <= py;
  end

endmodule

`default_nettype wire

// File: source/pixel_resolver.sv
`default_nettype none
`timescale 1ns/1ps

module pixel_resolver #(
  parameter int FRAME_W = 16,
  parameter int FRAME_H = 12
) (
  input wire                  sys_clk,
  input wire                  sys_rst,
  decode_if.resolver          dec,
  hit_if.resolver             hit,
  output logic                pixel_valid,
  output scene_pkg::coord_t   pixel_x,
  output scene_pkg::coord_t   pixel_y,
  output scene_pkg::color_t   pixel_color,
  output logic                frame_done
);
  import scene_pkg::*;

  localparam coord_t LAST_X = coord_t'(FRAME_W - 1);
  localparam coord_t LAST_Y = coord_t'(FRAME_H - 1);

  color_t bg_reg;
  logic   best_hit;   // some earlier slot of this pixel covered it
  depth_t best_depth;
  color_t best_color;
  logic   take;
  color_t pick_color;
  logic   pix_end;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      bg_reg <= '0;
    end else if (dec.bg_we) begin
      bg_reg <= dec.bg_color;
    end
  end

  // strict compare, so on a tie the lower slot is kept
  always_comb begin
    take = hit.cand_hit && (!best_hit || hit.cand_depth < best_depth);
    if (take) pick_color = hit.cand_color;
    else if (best_hit) pick_color = best_color;
    else pick_color = bg_reg;
    pix_end = hit.cand_valid && hit.cand_last;
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      best_hit    <= 1'b0;
      pixel_valid <= 1'b0;
      frame_done  <= 1'b0;
    end else begin
      pixel_valid <= pix_end;
      frame_done  <= pix_end && hit.cand_x == LAST_X && hit.cand_y == LAST_Y;
      if (pix_end) best_hit <= 1'b0;  // next pixel starts fresh
      else if (hit.cand_valid && take) best_hit <= 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (hit.cand_valid && take) begin
      best_depth <= hit.cand_depth;
      best_color <= hit.cand_color;
    end
    if (pix_end) begin
      pixel_x     <= hit.cand_x;
      pixel_y     <= hit.cand_y;
      pixel_color <= pick_color;
    end
  end

endmodule

`default_nettype wire

// File: source/scene_render_top.sv
`default_nettype none
`timescale 1ns/1ps

module scene_render_top #(
  parameter int FRAME_W    = 16,
  parameter int FRAME_H    = 12,
  parameter int NUM_SHAPES = 4
) (
  input wire                         sys_clk,
  input wire                         sys_rst,
  input wire                         inst_valid,
  input wire [scene_pkg::INST_W-1:0] inst_word,
  output logic                       busy,
  output logic                       pixel_valid,
  output scene_pkg::coord_t          pixel_x,
  output scene_pkg::coord_t          pixel_y,
  output scene_pkg::color_t          pixel_color,
  output logic                       frame_done
);

  decode_if dec_bus ();  // decode -> execute / result
  hit_if    hit_bus ();  // execute -> result

  scene_decoder u_decoder (
    .sys_clk    (sys_clk),
    .sys_rst    (sys_rst),
    .inst_valid (inst_valid),
    .inst_word  (inst_word),
    .busy       (busy),   // drops instructions during a frame
    .dec        (dec_bus.decoder)
  );

  raycast_engine #(
    .FRAME_W    (FRAME_W),
    .FRAME_H    (FRAME_H),
    .NUM_SHAPES (NUM_SHAPES)
  ) u_engine (
    .sys_clk (sys_clk),
    .sys_rst (sys_rst),
    .dec     (dec_bus.engine),
    .hit     (hit_bus.engine),
    .busy    (busy)
  );

  pixel_resolver #(
    .FRAME_W (FRAME_W),
    .FRAME_H (FRAME_H)
  ) u_resolver (
    .sys_clk     (sys_clk),
    .sys_rst     (sys_rst),
    .dec         (dec_bus.resolver),
    .hit         (hit_bus.resolver),
    .pixel_valid (pixel_valid),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .pixel_color (pixel_color),
    .frame_done  (frame_done)
  );

endmodule

`default_nettype wire

// File: test/scene_render_asserts.sv
`default_nettype none
`timescale 1ns/1ps

// protocol checks on the top-level strobes of scene_render_top
module scene_render_asserts #(
  parameter int NUM_SHAPES = 4
) (
  input wire sys_clk,
  input wire sys_rst,
  input wire busy,
  input wire pixel_valid,
  input wire frame_done
);

  int unsigned fail_cnt = 0; // watched by the testbench

  pixel_in_frame: assert property (@(posedge sys_clk) disable iff (sys_rst)
    pixel_valid |-> busy)
    else begin
      fail_cnt++;
      $error("pixel_valid seen while busy is low");
    end

  done_with_pixel: assert property (@(posedge sys_clk) disable iff (sys_rst)
    frame_done |-> pixel_valid)
    else begin
      fail_cnt++;
      $error("frame_done without pixel_valid");
    end

  // one pixel per NUM_SHAPES cycles until the last one
  pixel_spacing: assert property (@(posedge sys_clk) disable iff (sys_rst)
    pixel_valid && !frame_done |=> !pixel_valid [*NUM_SHAPES-1] ##1 pixel_valid)
    else begin
      fail_cnt++;
      $error("pixel_valid pulses not NUM_SHAPES cycles apart");
    end

  busy_release: assert property (@(posedge sys_clk) disable iff (sys_rst)
    frame_done |=> !busy)
    else begin
      fail_cnt++;
      $error("busy still high the cycle after frame_done");
    end

endmodule

bind scene_render_top scene_render_asserts #(.NUM_SHAPES(NUM_SHAPES)) u_asserts (
  .sys_clk     (sys_clk),
  .sys_rst     (sys_rst),
  .busy        (busy),
  .pixel_valid (pixel_valid),
  .frame_done  (frame_done)
);

`default_nettype wire

// File: test/scene_render_tb.sv
`default_nettype none
`timescale 1ns/1ps

module scene_render_tb;
  import scene_pkg::*;

  localparam int FRAME_W    = 16;
  localparam int FRAME_H    = 12;
  localparam int NUM_SHAPES = 4;
  localparam int WAIT_LIMIT = 64; // cycles allowed for any single wait

  logic              sys_clk;
  logic              sys_rst;
  logic              inst_valid;
  logic [INST_W-1:0] inst_word;
  logic              busy;
  logic              pixel_valid;
  coord_t            pixel_x;
  coord_t            pixel_y;
  color_t            pixel_color;
  logic              frame_done;

  shape_t            model_shape [NUM_SHAPES]; // scene as the DUT should hold it
  color_t            model_bg;
  logic [INST_W-1:0] junk_q [$];               // instructions the DUT must drop while busy
  int unsigned       lcg_state = 74;
  int                errors = 0;

  scene_render_top #(
    .FRAME_W    (FRAME_W),
    .FRAME_H    (FRAME_H),
    .NUM_SHAPES (NUM_SHAPES)
  ) dut0 (
    .sys_clk     (sys_clk),
    .sys_rst     (sys_rst),
    .inst_valid  (inst_valid),
    .inst_word   (inst_word),
    .busy        (busy),
    .pixel_valid (pixel_valid),
    .pixel_x     (pixel_x),
    .pixel_y     (pixel_y),
    .pixel_color (pixel_color),
    .frame_done  (frame_done)
  );

  always #10 sys_clk = ~sys_clk;

  // stop at the first failure of a bound protocol assertion
  always @(dut0.u_asserts.fail_cnt) begin
    if (dut0.u_asserts.fail_cnt != 0) begin
      fail_run("a protocol assertion in scene_render_asserts failed");
    end
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic shape_t mk_shape(input bit en, input int x0, input int y0,
                                      input int x1, input int y1, input int depth,
                                      input int color);
    shape_t s;
    s.enable = en;
    s.x0     = coord_t'(x0);
    s.y0     = coord_t'(y0);
    s.x1     = coord_t'(x1);
    s.y1     = coord_t'(y1);
    s.depth  = depth_t'(depth);
    s.color  = color_t'(color);
    return s;
  endfunction

  function automatic logic [INST_W-1:0] shape_word(input int slot, input shape_t s);
    inst_word_u w;
    w           = '0;
    w.shp.opcode = op_shape;
    w.shp.slot  = SLOT_W'(slot);
    w.shp.shape = s;
    return w;
  endfunction

  function automatic logic [INST_W-1:0] ctrl_word(input opcode_e op, input color_t c);
    inst_word_u w;
    w              = '0;
    w.ctl.opcode   = op;
    w.ctl.bg_color = c;
    return w;
  endfunction

  task automatic fail_run(input string why);
    errors++;
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_val(input string name, input int got, input int exp);
    assert (got == exp) else
      fail_run($sformatf("error %0t %s: got 0x%0h expected 0x%0h", $time, name, got, exp));
  endtask

  // caller sits 1 ns after a rising edge
  task automatic send_inst(input logic [INST_W-1:0] word);
    inst_valid = 1'b1;
    inst_word  = word;
    @(posedge sys_clk) #1;
    inst_valid = 1'b0;
  endtask

  task automatic write_shape(input int slot, input shape_t s);
    send_inst(shape_word(slot, s));
    model_shape[slot] = s;
  endtask

  task automatic write_bg(input color_t c);
    send_inst(ctrl_word(op_background, c));
    model_bg = c;
  endtask

  // nearest enabled covering shape, lower slot on equal depth, else background
  task automatic ref_color(input int x, input int y, output color_t c);
    bit     found;
    depth_t best;
    found = 1'b0;
    best  = '0;
    c     = model_bg;
    for (int s = 0; s < NUM_SHAPES; s++) begin
      if (model_shape[s].enable && x >= model_shape[s].x0 && x <= model_shape[s].x1 &&
          y >= model_shape[s].y0 && y <= model_shape[s].y1 &&
          (!found || model_shape[s].depth < best)) begin
        found = 1'b1;
        best  = model_shape[s].depth;
        c     = model_shape[s].color;
      end
    end
  endtask

  task automatic wait_idle();
    int cnt;
    cnt = 0;
    while (busy && cnt < WAIT_LIMIT) begin
      @(posedge sys_clk) #1;
      cnt++;
    end
    assert (!busy) else fail_run("timeout waiting for busy to fall after the frame");
  endtask

  // renders one frame and sends a junk instruction after each of the last n_junk pixels
  task automatic render_frame(input int n_junk);
    int     cnt;
    int     first_junk;
    color_t exp_c;
    first_junk = FRAME_W * FRAME_H - n_junk;
    send_inst(ctrl_word(op_render, '0));
    for (int idx = 0; idx < FRAME_W * FRAME_H; idx++) begin
      cnt = 0;
      @(posedge sys_clk) #1;
      while (!pixel_valid && cnt < WAIT_LIMIT) begin
        @(posedge sys_clk) #1;
        cnt++;
      end
      assert (pixel_valid) else fail_run($sformatf("timeout waiting for pixel %0d", idx));
      ref_color(idx % FRAME_W, idx / FRAME_W, exp_c);
      check_val("pixel_x", pixel_x, idx % FRAME_W);
      check_val("pixel_y", pixel_y, idx / FRAME_W);
      check_val("pixel_color", pixel_color, exp_c);
      check_val("frame_done", frame_done, idx == FRAME_W * FRAME_H - 1);
      if (idx >= first_junk) send_inst(junk_q[idx - first_junk]); // busy is still high
    end
    wait_idle();
    // a render taken during the drain would raise busy again here
    @(posedge sys_clk) #1;
    check_val("busy", busy, 0);
  endtask

  task automatic test_reset_frame();
    check_val("busy", busy, 0);
    check_val("pixel_valid", pixel_valid, 0);
    check_val("frame_done", frame_done, 0);
    render_frame(0);
  endtask

  task automatic test_one_shape();
    write_bg(12'h123);
    write_shape(0, mk_shape(1, 3, 2, 10, 8, 7, 12'habc));
    render_frame(0);
  endtask

  task automatic test_depth_order();
    write_shape(0, mk_shape(1, 2, 2, 9, 7, 5, 12'hf00));
    write_shape(1, mk_shape(1, 5, 4, 12, 10, 2, 12'h0f0));
    write_shape(2, mk_shape(1, 0, 0, 6, 5, 8, 12'h00f));
    render_frame(0);
    write_shape(2, mk_shape(1, 0, 0, 6, 5, 5, 12'h0ff)); // ties slot 0 on overlap
    write_shape(3, mk_shape(1, 8, 6, 14, 11, 2, 12'hf0f)); // ties slot 1
    render_frame(0);
    write_shape(1, mk_shape(0, 5, 4, 12, 10, 2, 12'h0f0));
    render_frame(0);
  endtask

  task automatic test_busy_drop();
    junk_q.delete();
    junk_q.push_back(ctrl_word(op_background, 12'hfff));
    junk_q.push_back(shape_word(1, mk_shape(1, 0, 0, 15, 11, 0, 12'h777)));
    junk_q.push_back(ctrl_word(op_render, '0));
    render_frame(junk_q.size());
    render_frame(0); // scene must be the old one
  endtask

  task automatic test_random_frames();
    int a;
    int b;
    int c;
    int d;
    for (int f = 0; f < 5; f++) begin
      write_bg(color_t'(lcg_next()));
      for (int s = 0; s < NUM_SHAPES; s++) begin
        a = lcg_next() % FRAME_W;
        b = lcg_next() % FRAME_W;
        c = lcg_next() % FRAME_H;
        d = lcg_next() % FRAME_H;
        write_shape(s, mk_shape((lcg_next() % 4) != 0, (a < b) ? a : b, (c < d) ? c : d,
                                (a < b) ? b : a, (c < d) ? d : c, lcg_next() % 4, lcg_next()));
      end
      render_frame(0);
    end
  endtask

  initial begin
    sys_clk    = 1'b0;
    sys_rst    = 1'b1;
    inst_valid = 1'b0;
    inst_word  = '0;
    model_bg   = '0;
    for (int s = 0; s < NUM_SHAPES; s++) model_shape[s] = '0;
    repeat (4) @(posedge sys_clk);
    #1 sys_rst = 1'b0;
    test_reset_frame();
    test_one_shape();
    test_depth_order();
    test_busy_drop();
    test_random_frames();
    if (errors == 0 && dut0.u_asserts.fail_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
source/scene_pkg.sv
source/decode_if.sv
source/hit_if.sv
source/scene_decoder.sv
source/raycast_engine.sv
source/pixel_resolver.sv
source/scene_render_top.sv
test/scene_render_asserts.sv
test/scene_render_tb.sv
